// ==== sources.f ====
rtl/rv_pkg.sv
rtl/pc_reg.sv
rtl/inst_decode.sv
rtl/core_ctrl.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/rv_core_top.sv
bench/rv_core_props.sv
bench/rv_core_tb.sv

// ==== bench/rv_core_tb.sv ====
/*
 * rv_core_top testbench
 * program memory model, reference register model, directed tests
 */
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

	localparam word_t ebreak_inst = 32'h0010_0073;
	localparam word_t ecall_inst  = 32'h0000_0073;

	logic    clk;
	logic    rst_n;
	word_t   inst;
	word_t   pc;
	retire_t retire;
	logic    halted;

	// program memory, one word per slot from reset_pc
	word_t   imem [256];
	// reference state built while the program is emitted
	word_t   ref_regs [32];
	retire_t exp_q [$];
	int      wp;
	word_t   halt_pc;
	int      errors;
	int      checks;
	int      tests;

	rv_core_top DUT (
		.clk(clk), .rst_n(rst_n), .inst(inst),
		.pc(pc), .retire(retire), .halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_word(string name, word_t got, word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_flag(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
		end
	endtask

	// fields only matter on a valid commit
	task automatic check_retire(retire_t got, retire_t exp);
		checks++;
		if (got.valid !== exp.valid) begin
			errors++;
			$display("CHECK FAILED t=%0t retire.valid got %b exp %b",
				$time, got.valid, exp.valid);
		end else if (exp.valid && (got !== exp)) begin
			errors++;
			$display("CHECK FAILED t=%0t retire got rd=%0d data=%h pc=%h %s",
				$time, got.rd, got.data, got.pc,
				$sformatf("exp rd=%0d data=%h pc=%h", exp.rd, exp.data, exp.pc));
		end
	endtask

	function automatic word_t sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// hand encoders, funct3 always 000 here
	function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, reg_idx_t rd,
		logic [6:0] op);
		return {imm, rs1, 3'b000, rd, op};
	endfunction

	function automatic word_t r_type(logic sub, reg_idx_t rs2, reg_idx_t rs1, reg_idx_t rd);
		return {1'b0, sub, 5'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	function automatic word_t j_type(logic [20:0] off, reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t slot_pc();
		return reset_pc + word_t'(wp) * 4;
	endfunction

	// empty program, fill is an illegal word that carries its address
	task automatic new_program();
		exp_q.delete();
		wp = 0;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		for (int i = 0; i < 256; i++)
			imem[i] = word_t'(i) << 7;
	endtask

	// place a word and queue what its commit must look like
	task automatic commit(word_t w, reg_idx_t rd, word_t val);
		retire_t e;
		e.valid = (rd != 5'd0);
		e.rd    = rd;
		e.data  = val;
		e.pc    = slot_pc();
		exp_q.push_back(e);
		imem[wp] = w;
		if (rd != 5'd0)
			ref_regs[rd] = val;
		wp++;
	endtask

	task automatic addi_step(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		commit(i_type(imm, rs1, rd, 7'b0010011), rd, ref_regs[rs1] + sext12(imm));
	endtask

	task automatic reg_reg_step(logic sub, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		word_t val;
		val = sub ? ref_regs[rs1] - ref_regs[rs2] : ref_regs[rs1] + ref_regs[rs2];
		commit(r_type(sub, rs2, rs1, rd), rd, val);
	endtask

	task automatic upper_step(logic pc_rel, reg_idx_t rd, logic [19:0] imm);
		word_t val;
		val = {imm, 12'b0} + (pc_rel ? slot_pc() : word_t'(0));
		commit({imm, rd, pc_rel ? 7'b0010111 : 7'b0110111}, rd, val);
	endtask

	task automatic jal_step(reg_idx_t rd, int off);
		word_t here;
		here = slot_pc();
		commit(j_type(21'(off), rd), rd, here + 32'd4);
		wp = wp - 1 + off / 4;
	endtask

	task automatic jalr_step(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		word_t here;
		word_t tgt;
		here = slot_pc();
		// low bit of the sum is dropped
		tgt = (ref_regs[rs1] + sext12(imm)) & ~word_t'(1);
		commit(i_type(imm, rs1, rd, 7'b1100111), rd, here + 32'd4);
		wp = int'((tgt - reset_pc) >> 2);
	endtask

	task automatic halt_step(word_t w);
		halt_pc = slot_pc();
		commit(w, 5'd0, '0);
	endtask

	task automatic drive_inst();
		word_t idx;
		idx = (pc - reset_pc) >> 2;
		inst = (idx < 256) ? imem[idx] : '0;
	endtask

	// ends on a falling edge with rst_n released
	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (10) begin
			@(negedge clk);
			drive_inst();
		end
		check_word("pc", pc, reset_pc);
		compare_flag("halted", halted, 1'b0);
		compare_flag("retire.valid", retire.valid, 1'b0);
		rst_n = 1'b1;
	endtask

	task automatic run_program();
		retire_t e;
		int      n;
		apply_reset();
		while (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			drive_inst();
			#1;
			check_word("pc", pc, e.pc);
			check_retire(retire, e);
			@(negedge clk);
		end
		n = 0;
		while (!halted && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!halted) begin
			errors++;
			$display("t=%0t core did not halt after the halting instruction", $time);
		end
		// frozen pc, no commits
		repeat (4) begin
			drive_inst();
			#1;
			check_word("pc", pc, halt_pc);
			compare_flag("halted", halted, 1'b1);
			check_retire(retire, retire_t'(0));
			@(negedge clk);
		end
	endtask

	task automatic finish_test(string name, int err_before);
		tests++;
		$display("test %s: %s, %0d errors", name,
			(errors == err_before) ? "ok" : "failed", errors - err_before);
	endtask

	task automatic reset_test();
		int e0;
		e0 = errors;
		new_program();
		// first word writes x1, so the trace must be held low in reset
		addi_step(5'd1, 5'd0, 12'h001);
		halt_step(ebreak_inst);
		run_program();
		finish_test("reset", e0);
	endtask

	task automatic arith_test();
		int e0;
		e0 = errors;
		new_program();
		repeat (12)
			addi_step(5'($urandom_range(31, 1)), 5'($urandom_range(31, 0)), 12'($urandom));
		repeat (12)
			reg_reg_step(1'($urandom), 5'($urandom_range(31, 1)),
				5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)));
		halt_step(ebreak_inst);
		run_program();
		finish_test("arith", e0);
	endtask

	task automatic upper_test();
		int e0;
		e0 = errors;
		new_program();
		upper_step(1'b0, 5'd5, 20'($urandom));
		upper_step(1'b1, 5'd6, 20'($urandom));
		upper_step(1'b0, 5'd7, 20'hfffff);
		addi_step(5'd7, 5'd7, 12'h7ff);
		// sum may wrap
		reg_reg_step(1'b0, 5'd8, 5'd5, 5'd6);
		upper_step(1'b1, 5'd9, 20'h80000);
		halt_step(ebreak_inst);
		run_program();
		finish_test("upper", e0);
	endtask

	task automatic jump_test();
		int e0;
		e0 = errors;
		new_program();
		upper_step(1'b0, 5'd3, 20'h80000);
		// skips slots 2 and 3
		jal_step(5'd1, 12);
		// odd target, lands on slot 16
		jalr_step(5'd2, 5'd3, 12'h041);
		// link to x0 is not traced
		jal_step(5'd0, 8);
		addi_step(5'd4, 5'd1, 12'h000);
		// back to slot 14
		jalr_step(5'd5, 5'd2, 12'h025);
		halt_step(ebreak_inst);
		run_program();
		finish_test("jump", e0);
	endtask

	task automatic ebreak_test();
		int e0;
		e0 = errors;
		new_program();
		addi_step(5'd7, 5'd0, 12'h005);
		halt_step(ebreak_inst);
		// would commit if the core ran on
		imem[wp] = i_type(12'h001, 5'd7, 5'd7, 7'b0010011);
		run_program();
		finish_test("ebreak", e0);
	endtask

	task automatic illegal_test();
		int e0;
		e0 = errors;
		new_program();
		addi_step(5'd9, 5'd0, 12'h123);
		halt_step(ecall_inst);
		imem[wp] = i_type(12'h001, 5'd9, 5'd9, 7'b0010011);
		run_program();
		// slli, an op-imm word with rd set that must not write
		new_program();
		addi_step(5'd9, 5'd0, 12'h123);
		halt_step(i_type(12'h001, 5'd9, 5'd9, 7'b0010011) | 32'h0000_1000);
		run_program();
		finish_test("illegal", e0);
	endtask

	initial begin
		void'($urandom(32'h89d5_4402));
		rst_n  = 1'b0;
		inst   = '0;
		errors = 0;
		checks = 0;
		tests  = 0;
		wp     = 0;
		reset_test();
		arith_test();
		upper_test();
		jump_test();
		ebreak_test();
		illegal_test();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/rv_core_props.sv ====
/*
 * core assertions, bound into rv_core_top
 * pc alignment, trace against register reads, halt behavior
 */
`timescale 1ns/1ns
`default_nettype none

module rv_core_props import rv_pkg::*; (
	input wire      clk,
	input wire      rst_n,
	input word_t    pc,
	input retire_t  retire,
	input logic     halted,
	input ctrl_t    ctrl,
	input reg_idx_t rs1,
	input word_t    rs1_data
);

	// fetch stays word aligned
	assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else $error("pc not word aligned");

	// a traced write is what the next read of that register returns
	assert property (@(posedge clk) disable iff (!rst_n)
		retire.valid |=> (rs1 != $past(retire.rd)) || (rs1_data == $past(retire.data)))
		else $error("traced write not seen in the register file");

	// halt is sticky and freezes the pc
	assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted && $stable(pc))
		else $error("halt dropped or pc moved while halted");

	// a halting word never commits
	assert property (@(posedge clk) disable iff (!rst_n)
		(ctrl.halt || ctrl.illegal) |-> !retire.valid)
		else $error("halting instruction committed a write");

endmodule

bind rv_core_top rv_core_props u_props (.*);

`default_nettype wire

// ==== rtl/rv_core_top.sv ====
/*
 * single-cycle rv32i core top
 * one instruction per clock, commit trace on the retire port
 */
`timescale 1ns/1ns
`default_nettype none

module rv_core_top import rv_pkg::*; (
	input  wire     clk,
	input  wire     rst_n,
	input  word_t   inst,
	output word_t   pc,
	output retire_t retire,
	output logic    halted
);

	ctrl_t    ctrl;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t    imm;
	word_t    rs1_data;
	word_t    rs2_data;
	word_t    result;
	word_t    wb_data;
	logic     wr_en;

	pc_reg u_pc_reg (
		.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .imm(imm), .target(result),
		.pc(pc), .halted(halted)
	);

	inst_decode u_inst_decode (
		.inst(inst), .imm_kind(ctrl.imm_kind),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm)
	);

	core_ctrl u_core_ctrl (.inst(inst), .ctrl(ctrl));

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .we(wr_en), .waddr(rd), .wdata(wb_data),
		.raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
	);

	alu u_alu (
		.ctrl(ctrl), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.imm(imm), .result(result)
	);

	// link value for jal and jalr
	assign wb_data = ctrl.wb_link ? (pc + word_t'(4)) : result;

	// no writes once halted
	assign wr_en = ctrl.reg_write & ~halted;

	// trace only real commits, x0 writes hidden
	assign retire.valid = rst_n & wr_en & (rd != reg_idx_t'(0));
	assign retire.rd    = rd;
	assign retire.data  = wb_data;
	assign retire.pc    = pc;

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
/*
 * operand select and adder
 * a is rs1 or pc, b is rs2 or imm, result wraps modulo 2^32
 */
`timescale 1ns/1ns
`default_nettype none

module alu import rv_pkg::*; (
	input  ctrl_t ctrl,
	input  word_t pc,
	input  word_t rs1_data,
	input  word_t rs2_data,
	input  word_t imm,
	output word_t result
);

	word_t op_a;
	word_t op_b;

	// auipc takes the pc
	assign op_a = ctrl.src_a_pc ? pc : rs1_data;

	// i and u types take the immediate
	assign op_b = ctrl.src_b_imm ? imm : rs2_data;

	always_comb begin
		case (ctrl.alu_op)
			alu_sub: begin
				result = op_a - op_b;
			end
			default: begin
				// carry out dropped
				result = op_a + op_b;
			end
		endcase
	end

	// jalr target also comes from here
	// pc_reg clears bit 0 of it

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
/*
 * 32 x 32 integer register file
 * two async reads, one clocked write, x0 hard zero
 */
`timescale 1ns/1ns
`default_nettype none

module reg_file import rv_pkg::*; (
	input  wire      clk,
	input  wire      rst_n,
	input  logic     we,
	input  reg_idx_t waddr,
	input  word_t    wdata,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	output word_t    rdata1,
	output word_t    rdata2
);

	word_t regs [32];

	// x0 discarded on write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (waddr != reg_idx_t'(0))) begin
			regs[waddr] <= wdata;
		end
	end

	// reads see the old value in the write cycle
	// x0 reads zero regardless of array contents
	always_comb begin
		if (raddr1 == reg_idx_t'(0))
			rdata1 = '0;
		else
			rdata1 = regs[raddr1];
	end

	always_comb begin
		if (raddr2 == reg_idx_t'(0))
			rdata2 = '0;
		else
			rdata2 = regs[raddr2];
	end

endmodule

`default_nettype wire

// ==== rtl/core_ctrl.sv ====
/*
 * main controller
 * opcode, funct3 and funct7 into the control struct, flags illegal words
 */
`timescale 1ns/1ns
`default_nettype none

module core_ctrl import rv_pkg::*; (
	input  word_t inst,
	output ctrl_t ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       f7_alt;
	logic       f7_rest_zero;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign f7_alt = inst[30];
	// only bit 30 may be set in funct7
	assign f7_rest_zero = (inst[31] == 1'b0) && (inst[29:25] == 5'b0);

	always_comb begin
		// safe default, nothing written, no jump
		ctrl          = '0;
		ctrl.alu_op   = alu_add;
		ctrl.imm_kind = imm_none;
		case (opcode)
			op_imm: begin
				// addi only
				ctrl.reg_write = 1'b1;
				ctrl.src_b_imm = 1'b1;
				ctrl.imm_kind  = imm_i;
				ctrl.illegal   = (funct3 != 3'b000);
			end
			op_reg: begin
				// add or sub
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = f7_alt ? alu_sub : alu_add;
				ctrl.illegal   = (funct3 != 3'b000) || !f7_rest_zero;
			end
			op_lui: begin
				// x0 + imm, rs1 forced to 0 in decode
				ctrl.reg_write = 1'b1;
				ctrl.src_b_imm = 1'b1;
				ctrl.imm_kind  = imm_u;
			end
			op_auipc: begin
				ctrl.reg_write = 1'b1;
				ctrl.src_a_pc  = 1'b1;
				ctrl.src_b_imm = 1'b1;
				ctrl.imm_kind  = imm_u;
			end
			op_jal: begin
				// target pc + imm computed in pc_reg
				ctrl.reg_write = 1'b1;
				ctrl.wb_link   = 1'b1;
				ctrl.jump      = 1'b1;
				ctrl.imm_kind  = imm_j;
			end
			op_jalr: begin
				// target rs1 + imm from alu
				ctrl.reg_write = 1'b1;
				ctrl.wb_link   = 1'b1;
				ctrl.jump      = 1'b1;
				ctrl.jump_reg  = 1'b1;
				ctrl.src_b_imm = 1'b1;
				ctrl.imm_kind  = imm_i;
				ctrl.illegal   = (funct3 != 3'b000);
			end
			op_system: begin
				// ebreak stops, ecall and csr ops unsupported
				ctrl.halt    = (inst == ebreak_word);
				ctrl.illegal = (inst != ebreak_word);
			end
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
		// an illegal word halts like ebreak and never commits
		if (ctrl.illegal)
			ctrl.reg_write = 1'b0;
	end

endmodule

`default_nettype wire

// ==== rtl/inst_decode.sv ====
/*
 * instruction field decode
 * register indices and sign-extended immediate of the selected kind
 */
`timescale 1ns/1ns
`default_nettype none

module inst_decode import rv_pkg::*; (
	input  word_t     inst,
	input  imm_kind_t imm_kind,
	output reg_idx_t  rs1,
	output reg_idx_t  rs2,
	output reg_idx_t  rd,
	output word_t     imm
);

	word_t imm_i_val;
	word_t imm_u_val;
	word_t imm_j_val;

	// fixed rv32 field positions
	assign rd  = inst[11:7];
	assign rs2 = inst[24:20];

	// u-type reads x0 so lui becomes 0 + imm
	// auipc takes pc as operand a, rs1 unused there
	assign rs1 = (imm_kind == imm_u) ? reg_idx_t'(0) : inst[19:15];

	// i-type, 12 bits sign extended
	assign imm_i_val = {{20{inst[31]}}, inst[31:20]};

	// u-type, upper 20 bits, low 12 zero
	assign imm_u_val = {inst[31:12], 12'b0};

	// j-type, scrambled 20 bit offset
	// bit 0 always zero
	assign imm_j_val = {
		{12{inst[31]}},
		inst[19:12],
		inst[20],
		inst[30:21],
		1'b0
	};

	always_comb begin
		case (imm_kind)
			imm_i: begin
				imm = imm_i_val;
			end
			imm_u: begin
				imm = imm_u_val;
			end
			imm_j: begin
				imm = imm_j_val;
			end
			default: begin
				// imm_none, no immediate in use
				imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/pc_reg.sv ====
/*
 * program counter with next-pc select
 * freezes and latches halt on ebreak or illegal encoding
 */
`timescale 1ns/1ns
`default_nettype none

module pc_reg import rv_pkg::*; (
	input  wire   clk,
	input  wire   rst_n,
	input  ctrl_t ctrl,
	input  word_t imm,
	input  word_t target,
	output word_t pc,
	output logic  halted
);

	word_t pc_next;
	logic  stop;

	// halting instruction keeps its own address
	assign stop = ctrl.halt | ctrl.illegal | halted;

	always_comb begin
		if (ctrl.jump && ctrl.jump_reg) begin
			// jalr clears bit 0
			pc_next = {target[xlen-1:1], 1'b0};
		end else if (ctrl.jump) begin
			pc_next = pc + imm;
		end else begin
			pc_next = pc + word_t'(4);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc     <= reset_pc;
			halted <= 1'b0;
		end else begin
			if (!stop)
				pc <= pc_next;
			// sticky until reset
			if (ctrl.halt || ctrl.illegal)
				halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rv_pkg.sv ====
/*
 * rv32i core package
 * word and index types, opcodes, control and commit trace structs
 */
`default_nettype none

package rv_pkg;

	// data path width
	localparam int xlen = 32;

	// first fetch after reset
	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0]      reg_idx_t;

	// major opcodes, inst[6:0]
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_system = 7'b1110011;

	// ebreak is the only system encoding accepted
	localparam word_t ebreak_word = 32'h0010_0073;

	// immediate layout picked by the controller
	typedef enum logic [2:0] {
		imm_i    = 3'd0,
		imm_u    = 3'd1,
		imm_j    = 3'd2,
		imm_none = 3'd3
	} imm_kind_t;

	// adder direction
	typedef enum logic {
		alu_add = 1'b0,
		alu_sub = 1'b1
	} alu_op_t;

	// per-instruction control word
	typedef struct packed {
		logic      reg_write;
		logic      src_a_pc;
		logic      src_b_imm;
		alu_op_t   alu_op;
		imm_kind_t imm_kind;
		// write back pc+4 instead of alu result
		logic      wb_link;
		logic      jump;
		// target from alu, jalr
		logic      jump_reg;
		logic      halt;
		logic      illegal;
	} ctrl_t;

	// one register write commit
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
		word_t    pc;
	} retire_t;

endpackage

`default_nettype wire
